// File: logic/rt_regs_pkg.sv
/* register map of the real-time block; byte offsets, word access only
   unaligned or unmapped offsets answer slverr */
`default_nettype none

package rt_regs_pkg;

    localparam int addr_w = 8;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int resp_w = 2;

    // byte offsets
    localparam logic [addr_w-1:0] reg_control       = 8'h00; // bit0 entropy fifo reset
    localparam logic [addr_w-1:0] reg_itrng_divisor = 8'h04;
    localparam logic [addr_w-1:0] reg_cycle_count   = 8'h08; // read only
    localparam logic [addr_w-1:0] reg_log_data      = 8'h0C; // read pops
    localparam logic [addr_w-1:0] reg_log_status    = 8'h10;
    localparam logic [addr_w-1:0] reg_itrng_data    = 8'h14; // write pushes
    localparam logic [addr_w-1:0] reg_itrng_status  = 8'h18;

    localparam logic [resp_w-1:0] resp_okay   = 2'd0;
    localparam logic [resp_w-1:0] resp_slverr = 2'd2;

    // status word layout
    localparam int status_empty_bit = 0;
    localparam int status_full_bit  = 1;

    // log data word, seen either raw or split into fields
    typedef union packed {
        logic [data_w-1:0] raw;
        struct packed {
            logic [22:0] unused;
            logic        valid;   // head char present
            logic [7:0]  ch;
        } f;
    } log_word_u;

endpackage

`default_nettype wire

// File: logic/fifo_cfg_pkg.sv
/* sizes of the log and entropy FIFOs; depths must stay powers of two */
`default_nettype none

package fifo_cfg_pkg;

    // log character fifo
    localparam int log_char_w = 8;
    localparam int log_depth  = 16;
    localparam int log_ptr_w  = $clog2(log_depth);

    // entropy fifo, words in and nibbles out
    localparam int itrng_word_w        = 32;
    localparam int itrng_nib_w         = 4;
    localparam int itrng_nibs_per_word = itrng_word_w / itrng_nib_w;
    localparam int itrng_nib_idx_w     = $clog2(itrng_nibs_per_word);
    localparam int itrng_depth         = 4;
    localparam int itrng_ptr_w         = $clog2(itrng_depth);

endpackage

`default_nettype wire

// File: logic/log_char_fifo.sv
/* chars arriving while full are dropped; head is valid only when not empty */
`timescale 1ns/1ns
`default_nettype none

module log_char_fifo import fifo_cfg_pkg::*; (
    input  wire logic                  core_clk,
    input  wire logic                  hwif_out,        // async, active low
    input  wire logic [log_char_w-1:0] log_char,
    input  wire logic                  log_char_valid,
    input  wire logic                  log_pop,
    output logic      [log_char_w-1:0] log_head,
    output logic                       log_empty,
    output logic                       log_full
);

    logic [log_char_w-1:0] mem [log_depth];
    logic [log_ptr_w-1:0]  wr_ptr;
    logic [log_ptr_w-1:0]  rd_ptr;
    logic [log_ptr_w:0]    count;     // one extra bit so full fits
    logic                  do_push;
    logic                  do_pop;

    assign log_empty = (count == '0);
    assign log_full  = (count == (log_ptr_w + 1)'(log_depth));
    assign log_head  = mem[rd_ptr];

    assign do_push = log_char_valid && !log_full;
    assign do_pop  = log_pop && !log_empty;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= log_char;
        end
    end

endmodule

`default_nettype wire

// File: logic/itrng_nibble_fifo.sv
/* nibbles leave low first, one per pacer zero with etrng_req high;
   flush is a level and holds the FIFO empty, pushes are dropped meanwhile */
`timescale 1ns/1ns
`default_nettype none

module itrng_nibble_fifo import fifo_cfg_pkg::*; (
    input  wire logic                    core_clk,
    input  wire logic                    hwif_out,   // async, active low
    input  wire logic                    itrng_push,
    input  wire logic [itrng_word_w-1:0] itrng_word,
    input  wire logic                    itrng_flush,
    input  wire logic [31:0]             divisor,
    input  wire logic                    etrng_req,
    output logic      [itrng_nib_w-1:0]  itrng_data,
    output logic                         itrng_valid,
    output logic                         itrng_empty,
    output logic                         itrng_full
);

    logic [itrng_word_w-1:0]    words [itrng_depth];
    logic [itrng_ptr_w-1:0]     wr_ptr;
    logic [itrng_ptr_w-1:0]     rd_ptr;
    logic [itrng_ptr_w:0]       count;      // words held
    logic [itrng_nib_idx_w-1:0] nib_idx;    // next nibble of head word
    logic [31:0]                pace_cnt;
    logic                       pace_zero;
    logic                       do_push;
    logic                       do_pop;
    logic                       retire;
    logic [itrng_word_w-1:0]    head_word;

    assign itrng_empty = (count == '0);
    assign itrng_full  = (count == (itrng_ptr_w + 1)'(itrng_depth));

    assign pace_zero = (pace_cnt == '0);
    assign do_push   = itrng_push && !itrng_full && !itrng_flush;
    assign do_pop    = pace_zero && etrng_req && !itrng_empty && !itrng_flush;
    assign retire    = do_pop && (nib_idx == itrng_nib_idx_w'(itrng_nibs_per_word - 1));
    assign head_word = words[rd_ptr];

    // request pacer, reloads whenever it hits zero
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            pace_cnt <= '0;
        end else if (pace_zero) begin
            pace_cnt <= divisor;
        end else begin
            pace_cnt <= pace_cnt - 1'b1;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else if (itrng_flush) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= do_pop;                 // one cycle after the pop
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  nib_idx <= nib_idx + 1'b1; // wraps after eighth nibble
            if (retire)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // word storage and output nibble
    always_ff @(posedge core_clk) begin
        if (do_push) begin
            words[wr_ptr] <= itrng_word;
        end
        if (do_pop) begin
            itrng_data <= head_word[nib_idx * itrng_nib_w +: itrng_nib_w];
        end
    end

endmodule

`default_nettype wire

// File: logic/rt_reg_block.sv
/* AXI4-Lite slave with one outstanding write and one outstanding read;
   wstrb applies to control and divisor only and an entropy push takes the whole word */
`timescale 1ns/1ns
`default_nettype none

module rt_reg_block import rt_regs_pkg::*, fifo_cfg_pkg::*; (
    input  wire logic                    core_clk,
    input  wire logic                    hwif_out,   // async, active low

    input  wire logic                    awvalid,
    output logic                         awready,
    input  wire logic [addr_w-1:0]       awaddr,
    input  wire logic                    wvalid,
    output logic                         wready,
    input  wire logic [data_w-1:0]       wdata,
    input  wire logic [strb_w-1:0]       wstrb,
    output logic                         bvalid,
    input  wire logic                    bready,
    output logic      [resp_w-1:0]       bresp,
    input  wire logic                    arvalid,
    output logic                         arready,
    input  wire logic [addr_w-1:0]       araddr,
    output logic                         rvalid,
    input  wire logic                    rready,
    output logic      [data_w-1:0]       rdata,
    output logic      [resp_w-1:0]       rresp,

    input  wire logic [log_char_w-1:0]   log_head,
    input  wire logic                    log_empty,
    input  wire logic                    log_full,
    input  wire logic                    itrng_empty,
    input  wire logic                    itrng_full,
    output logic                         log_pop,
    output logic                         itrng_push,
    output logic      [itrng_word_w-1:0] itrng_word,
    output logic                         itrng_flush,
    output logic      [31:0]             divisor
);

    logic              wr_ready_q;   // shared by aw and w
    logic              wr_fire;
    logic              rd_fire;
    logic [resp_w-1:0] wr_resp;
    logic [resp_w-1:0] rd_resp;
    logic [data_w-1:0] rd_word;
    logic [31:0]       cycle_count;
    log_word_u         log_word;
    logic              ctrl_flush;   // control register holds only the flush bit

    assign awready = wr_ready_q;
    assign wready  = wr_ready_q;

    assign wr_fire = wr_ready_q && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    assign itrng_flush = ctrl_flush;
    assign itrng_push  = wr_fire && (awaddr == reg_itrng_data);
    assign itrng_word  = wdata;
    assign log_pop     = rd_fire && (araddr == reg_log_data) && !log_empty;

    // write response by offset
    always_comb begin
        wr_resp = resp_slverr;
        case (awaddr)
            reg_control, reg_itrng_divisor, reg_itrng_data: wr_resp = resp_okay;
            default: ;
        endcase
    end

    // read data by offset
    always_comb begin
        log_word         = '0;
        log_word.f.valid = !log_empty;
        log_word.f.ch    = log_empty ? '0 : log_head;
        rd_word          = '0;
        rd_resp          = resp_okay;
        case (araddr)
            reg_control:       rd_word[0] = ctrl_flush;
            reg_itrng_divisor: rd_word = divisor;
            reg_cycle_count:   rd_word = cycle_count;
            reg_log_data:      rd_word = log_word.raw;
            reg_log_status: begin
                rd_word[status_empty_bit] = log_empty;
                rd_word[status_full_bit]  = log_full;
            end
            reg_itrng_data:    rd_word = '0;         // write only
            reg_itrng_status: begin
                rd_word[status_empty_bit] = itrng_empty;
                rd_word[status_full_bit]  = itrng_full;
            end
            default:           rd_resp = resp_slverr;
        endcase
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ready_q  <= 1'b0;
            bvalid      <= 1'b0;
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            ctrl_flush  <= 1'b0;
            divisor     <= '0;
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;

            // write channel
            wr_ready_q <= awvalid && wvalid && !bvalid && !wr_ready_q;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (wr_fire && (awaddr == reg_control) && wstrb[0]) begin
                ctrl_flush <= wdata[0];
            end
            if (wr_fire && (awaddr == reg_itrng_divisor)) begin
                for (int i = 0; i < strb_w; i++) begin
                    if (wstrb[i]) divisor[i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end

            // read channel
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload captured on accept and held until taken
    always_ff @(posedge core_clk) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

// File: logic/fpga_rt_top.sv
/* real-time register side; log chars have no back-pressure and drop when full */
`timescale 1ns/1ns
`default_nettype none

module fpga_rt_top import rt_regs_pkg::*, fifo_cfg_pkg::*; (
    input  wire logic                   core_clk,
    input  wire logic                   hwif_out,       // async, active low

    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire logic [addr_w-1:0]      awaddr,
    input  wire logic                   wvalid,
    output logic                        wready,
    input  wire logic [data_w-1:0]      wdata,
    input  wire logic [strb_w-1:0]      wstrb,
    output logic                        bvalid,
    input  wire logic                   bready,
    output logic      [resp_w-1:0]      bresp,
    input  wire logic                   arvalid,
    output logic                        arready,
    input  wire logic [addr_w-1:0]      araddr,
    output logic                        rvalid,
    input  wire logic                   rready,
    output logic      [data_w-1:0]      rdata,
    output logic      [resp_w-1:0]      rresp,

    input  wire logic [log_char_w-1:0]  log_char,
    input  wire logic                   log_char_valid,

    input  wire logic                   etrng_req,
    output logic      [itrng_nib_w-1:0] itrng_data,
    output logic                        itrng_valid
);

    logic [log_char_w-1:0]   log_head;
    logic                    log_empty;
    logic                    log_full;
    logic                    log_pop;
    logic                    itrng_empty;
    logic                    itrng_full;
    logic                    itrng_push;
    logic [itrng_word_w-1:0] itrng_word;
    logic                    itrng_flush;
    logic [31:0]             divisor;

    rt_reg_block regs_i (
        .core_clk, .hwif_out,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .log_head, .log_empty, .log_full,
        .itrng_empty, .itrng_full,
        .log_pop, .itrng_push, .itrng_word, .itrng_flush, .divisor
    );

    log_char_fifo log_fifo_i (
        .core_clk, .hwif_out,
        .log_char, .log_char_valid, .log_pop,
        .log_head, .log_empty, .log_full
    );

    itrng_nibble_fifo itrng_fifo_i (
        .core_clk, .hwif_out,
        .itrng_push, .itrng_word, .itrng_flush, .divisor,
        .etrng_req, .itrng_data, .itrng_valid,
        .itrng_empty, .itrng_full
    );

endmodule

`default_nettype wire

// File: test/fpga_rt_asserts.sv
/* concurrent checks on the AXI4-Lite responses and the entropy output;
   bound into fpga_rt_top, fail_count is read back by the testbench */
`timescale 1ns/1ns
`default_nettype none

module fpga_rt_asserts import rt_regs_pkg::*; (
    input wire logic              core_clk,
    input wire logic              hwif_out,
    input wire logic              awready,
    input wire logic              bvalid,
    input wire logic              bready,
    input wire logic [resp_w-1:0] bresp,
    input wire logic              rvalid,
    input wire logic              rready,
    input wire logic [data_w-1:0] rdata,
    input wire logic              etrng_req,
    input wire logic              itrng_valid
);

    int unsigned fail_count = 0;

    b_hold_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            fail_count = fail_count + 1;
            $error("write response dropped or changed before bready");
        end

    r_hold_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            fail_count = fail_count + 1;
            $error("read response dropped or changed before rready");
        end

    // one write outstanding at a time
    aw_block_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        bvalid |-> !awready)
        else begin
            fail_count = fail_count + 1;
            $error("awready high while a write response is pending");
        end

    itrng_req_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> $past(etrng_req))
        else begin
            fail_count = fail_count + 1;
            $error("itrng_valid without etrng_req in the cycle before");
        end

endmodule

bind fpga_rt_top fpga_rt_asserts asserts_i (.*);

`default_nettype wire

// File: test/tb_fpga_rt.sv
/* drives fpga_rt_top over AXI4-Lite and the log and entropy ports;
   handshake and entropy timing rules live in the bound fpga_rt_asserts */
`timescale 1ns/1ns
`default_nettype none

module tb_fpga_rt import rt_regs_pkg::*; ();

    // about 80 transfers of under 30 cycles each plus the nibble drains and a wide margin
    localparam int unsigned max_cycles = 20000;

    logic        core_clk;
    logic        hwif_out;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic [7:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        arvalid, arready, rvalid, rready;
    logic [7:0]  log_char;
    logic        log_char_valid;
    logic        etrng_req;
    logic [3:0]  itrng_data;
    logic        itrng_valid;

    int unsigned cycles;
    int unsigned last_accept;         // tb cycle of the latest read accept
    bit          run_done;
    logic [7:0]  log_model [$];
    logic [31:0] ent_words [$];
    logic [3:0]  nib_q [$];
    int unsigned pulse_q [$];

    fpga_rt_top dut_i (.*);

    always #10 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            stop_with_failure("timeout: tests did not finish within the cycle limit");
        end
    end

    // entropy output captured between edges
    always @(negedge core_clk) begin
        if (hwif_out === 1'b1 && itrng_valid) begin
            nib_q.push_back(itrng_data);
            pulse_q.push_back(cycles);
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        run_done = 1'b1;
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                        name, got, exp));
        end
    endtask

    function automatic logic ready_with_stall();
        return $urandom_range(2, 0) != 0;  // low about a third of the time
    endfunction

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] exp_resp);
        logic done;
        @(posedge core_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        done = 1'b0;
        while (!done) begin
            @(negedge core_clk);
            done = awready && wready;
        end
        @(posedge core_clk);              // accepting edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= ready_with_stall();
        done = 1'b0;
        while (!done) begin
            @(negedge core_clk);
            done = bvalid && bready;
            if (!done) begin
                @(posedge core_clk);
                bready <= ready_with_stall();
            end
        end
        check_value($sformatf("bresp at 0x%02h", addr), 32'(bresp), 32'(exp_resp));
        @(posedge core_clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, input logic [1:0] exp_resp,
                             output logic [31:0] data);
        logic done;
        @(posedge core_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        done = 1'b0;
        while (!done) begin
            @(negedge core_clk);
            done = arready;
        end
        last_accept = cycles;
        @(posedge core_clk);
        arvalid <= 1'b0;
        rready  <= ready_with_stall();
        done = 1'b0;
        while (!done) begin
            @(negedge core_clk);
            done = rvalid && rready;
            if (!done) begin
                @(posedge core_clk);
                rready <= ready_with_stall();
            end
        end
        data = rdata;
        check_value($sformatf("rresp at 0x%02h", addr), 32'(rresp), 32'(exp_resp));
        @(posedge core_clk);
        rready <= 1'b0;
    endtask

    task automatic push_log_chars(input int count);
        logic [7:0] ch;
        for (int i = 0; i < count; i++) begin
            @(posedge core_clk);
            ch = 8'($urandom);
            log_char       <= ch;
            log_char_valid <= 1'b1;
            if (log_model.size() < 16) log_model.push_back(ch);  // full fifo drops
        end
        @(posedge core_clk);
        log_char_valid <= 1'b0;
    endtask

    // valid at bit 8 over the head char and all zero when empty
    function automatic logic [31:0] expected_log_word();
        return (log_model.size() != 0) ? (32'h100 | 32'(log_model.pop_front())) : 32'd0;
    endfunction

    task automatic check_nibbles();
        for (int i = 0; i < nib_q.size(); i++) begin
            check_value("itrng_data", 32'(nib_q[i]),
                        (ent_words[i / 8] >> (4 * (i % 8))) & 32'hF);
        end
    endtask

    initial begin
        logic [31:0] rd, wr, val, first, second;
        int unsigned first_accept;
        core_clk = 1'b0;
        hwif_out = 1'b0;
        cycles = 0;
        run_done = 1'b0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        {awaddr, araddr, wdata, wstrb} = '0;
        log_char = '0;
        log_char_valid = 1'b0;
        etrng_req = 1'b0;
        wr = $urandom(32'h6122);
        repeat (10) @(posedge core_clk);
        hwif_out <= 1'b1;
        @(posedge core_clk);

        // register access with a small divisor so the pacer reload stays short
        val = $urandom & 32'hFF;
        axil_write(reg_itrng_divisor, val, 4'hF, resp_okay);
        axil_read(reg_itrng_divisor, resp_okay, rd);
        check_value("divisor", rd, val);
        wr = $urandom;
        axil_write(reg_itrng_divisor, wr, 4'h1, resp_okay);   // low byte lane only
        val = {val[31:8], wr[7:0]};
        axil_read(reg_itrng_divisor, resp_okay, rd);
        check_value("divisor", rd, val);
        wr = $urandom;
        axil_write(reg_control, wr, 4'hF, resp_okay);
        axil_read(reg_control, resp_okay, rd);
        check_value("control", rd, {31'd0, wr[0]});
        axil_write(reg_control, 32'd0, 4'hF, resp_okay);
        axil_write(8'h1C, $urandom, 4'hF, resp_slverr);
        axil_read(8'h1C, resp_slverr, rd);
        check_value("rdata unmapped", rd, 32'd0);
        axil_write(reg_cycle_count, $urandom, 4'hF, resp_slverr);

        // log fifo with one read past the last char
        push_log_chars(5);
        repeat (6) begin
            axil_read(reg_log_data, resp_okay, rd);
            check_value("log_data", rd, expected_log_word());
        end
        axil_read(reg_log_status, resp_okay, rd);
        check_value("log_status", rd, 32'h1);

        // overflow keeps the first 16
        push_log_chars(20);
        axil_read(reg_log_status, resp_okay, rd);
        check_value("log_status", rd, 32'h2);
        repeat (17) begin
            axil_read(reg_log_data, resp_okay, rd);
            check_value("log_data", rd, expected_log_word());
        end
        axil_read(reg_log_status, resp_okay, rd);
        check_value("log_status", rd, 32'h1);

        // entropy at full rate
        axil_write(reg_itrng_divisor, 32'd0, 4'hF, resp_okay);
        @(posedge core_clk);
        etrng_req <= 1'b1;
        nib_q.delete();
        pulse_q.delete();
        ent_words.push_back($urandom);
        ent_words.push_back($urandom);
        axil_write(reg_itrng_data, ent_words[0], 4'hF, resp_okay);
        axil_write(reg_itrng_data, ent_words[1], 4'h3, resp_okay);  // whole word anyway
        while (nib_q.size() < 16) @(negedge core_clk);
        check_nibbles();
        axil_read(reg_itrng_status, resp_okay, rd);
        check_value("itrng_status", rd, 32'h1);

        // paced output and then a flush
        axil_write(reg_itrng_divisor, 32'd3, 4'hF, resp_okay);
        ent_words.delete();
        nib_q.delete();
        pulse_q.delete();
        ent_words.push_back($urandom);
        axil_write(reg_itrng_data, ent_words[0], 4'hF, resp_okay);
        while (nib_q.size() < 8) @(negedge core_clk);
        check_nibbles();
        for (int i = 1; i < pulse_q.size(); i++) begin
            assert (pulse_q[i] - pulse_q[i - 1] >= 4) else begin
                stop_with_failure($sformatf("itrng_valid pulses %0d cycles apart at divisor 3",
                                            pulse_q[i] - pulse_q[i - 1]));
            end
        end
        @(posedge core_clk);
        etrng_req <= 1'b0;
        axil_write(reg_itrng_data, $urandom, 4'hF, resp_okay);
        axil_read(reg_itrng_status, resp_okay, rd);
        check_value("itrng_status", rd, 32'h0);
        axil_write(reg_control, 32'd1, 4'hF, resp_okay);
        axil_read(reg_itrng_status, resp_okay, rd);
        check_value("itrng_status", rd, 32'h1);
        axil_write(reg_control, 32'd0, 4'hF, resp_okay);
        axil_read(reg_itrng_status, resp_okay, rd);
        check_value("itrng_status", rd, 32'h1);

        // cycle counter against the tb count of read accepts
        axil_read(reg_cycle_count, resp_okay, first);
        first_accept = last_accept;
        repeat ($urandom_range(10, 3)) @(posedge core_clk);
        axil_read(reg_cycle_count, resp_okay, second);
        assert (second > first && second - first >= last_accept - first_accept) else begin
            stop_with_failure($sformatf("Mismatch cycle_count: 0x%08h then 0x%08h, gap 0x%08h",
                                        first, second, last_accept - first_accept));
        end

        repeat (4) @(posedge core_clk);
        run_done = 1'b1;
        if (dut_i.asserts_i.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("bound assertions failed %0d times",
                                        dut_i.asserts_i.fail_count));
        end
    end

    // run stopped from elsewhere such as a bound assertion
    final begin
        if (!run_done) $display("SIMULATION FAILED");
    end

endmodule

`default_nettype wire

// File: sources.f
logic/rt_regs_pkg.sv
logic/fifo_cfg_pkg.sv
logic/log_char_fifo.sv
logic/itrng_nibble_fifo.sv
logic/rt_reg_block.sv
logic/fpga_rt_top.sv
test/fpga_rt_asserts.sv
test/tb_fpga_rt.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_fpga_rt -f sources.f \
    || { echo "verilator build failed" >&2; exit 1; }

sim_out="$(./obj_dir/Vtb_fpga_rt 2>&1)"
echo "$sim_out"

grep -qx "SIMULATION PASSED" <<< "$sim_out" && exit 0 || exit 1
